//--- include/z80_config.svh
`ifndef Z80_CONFIG_SVH
`define Z80_CONFIG_SVH

// byte address and data bus widths
`define Z80_ADDR_W 16
`define Z80_DATA_W 8

// prefix bytes that open a second opcode byte
`define Z80_PFX_CB 8'hCB
`define Z80_PFX_ED 8'hED
`define Z80_PFX_DD 8'hDD
`define Z80_PFX_FD 8'hFD

// longest instruction in the unprefixed and CB tables
`define Z80_MAX_LEN 3

`endif

//--- hw/z80Pkg.sv
`default_nettype none

`include "z80_config.svh"

package z80Pkg;

    typedef logic [$clog2(`Z80_MAX_LEN + 1) - 1:0] insnLen_t;

    typedef enum logic [5:0] {
        grpNop, grpLdDdNn, grpLdIndBcdeA, grpIncDecDd, grpIncDecReg,
        grpRrRlca, grpAddHlDd, grpDaa, grpCpl, grpIncDecIndHl,
        grpLdAIndBcde, grpLdRegN, grpLdIndNnHl, grpLdHlIndNn, grpLdIndHlN,
        grpLdRegReg, grpLdIndNnA, grpScf, grpLdAIndNn, grpCcf,
        grpLdIndHlReg, grpHalt, grpJp, grpJpCond, grpJpIndHl,
        grpJr, grpJrCond, grpDjnz, grpCall, grpCallCond,
        grpRet, grpRetCond, grpPopQq, grpPushQq, grpExAfAf2,
        grpExIndSpHl, grpExDeHl, grpExx, grpLdSpHl, grpAluAReg,
        grpAluAIndHl, grpAluAN, grpEiDi,
        // CB page
        grpRotReg, grpRotIndHl, grpShiftReg, grpShiftIndHl,
        grpBitReg, grpBitIndHl, grpResReg, grpResIndHl,
        grpSetReg, grpSetIndHl,
        grpUnsupportedPrefix,
        grpIllegal
    } insnGroup_e;

    typedef enum logic [2:0] {
        stIdle,
        stOpcode,
        stCbOpcode,
        stOperand,
        stEmit
    } framerState_e;

endpackage

`default_nettype wire

//--- hw/opFetchIf.sv
`timescale 1ns/1ps
`default_nettype none

`include "z80_config.svh"

interface opFetchIf;

    logic req;
    logic [`Z80_ADDR_W-1:0] addr;
    logic [`Z80_DATA_W-1:0] data;
    // one cycle, qualifies data
    logic done;

    modport initiator (output req, output addr, input data, input done);
    modport target (input req, input addr, output data, output done);

endinterface

`default_nettype wire

//--- hw/wbOpFetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "z80_config.svh"

module wbOpFetch (
    input  logic                   clk,
    input  logic                   arstN,
    opFetchIf.target               fetch,
    output logic                   wbCyc,
    output logic                   wbStb,
    output logic                   wbWe,
    output logic [`Z80_ADDR_W-1:0] wbAdr,
    input  logic [`Z80_DATA_W-1:0] wbDatI,
    input  logic                   wbAck
);

    logic cyc;
    logic doneQ;
    logic launch;
    logic [`Z80_DATA_W-1:0] dataQ;

    // no new cycle while done is still showing, so cyc stays low at least one cycle
    assign launch = !cyc && !doneQ && fetch.req;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cyc <= 1'b0;
            doneQ <= 1'b0;
        end else begin
            doneQ <= 1'b0;
            if (cyc) begin
                if (wbAck) begin
                    cyc <= 1'b0;
                    doneQ <= 1'b1;
                end
            end else if (launch) begin
                cyc <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            wbAdr <= fetch.addr;
        end
        if (cyc && wbAck) begin
            dataQ <= wbDatI;
        end
    end

    assign wbCyc = cyc;
    assign wbStb = cyc;
    assign wbWe = 1'b0;
    assign fetch.data = dataQ;
    assign fetch.done = doneQ;

endmodule

`default_nettype wire

//--- hw/baseOpDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "z80_config.svh"

module baseOpDecoder import z80Pkg::*; (
    input  logic [7:0] opcode,
    output insnGroup_e group,
    output insnLen_t   length
);

    // first match wins, so the specific codes sit above the wider patterns
    always_comb begin
        casez (opcode)
            `Z80_PFX_ED, `Z80_PFX_DD, `Z80_PFX_FD: group = grpUnsupportedPrefix;
            8'h00: group = grpNop;
            8'h08: group = grpExAfAf2;
            8'h10: group = grpDjnz;
            8'h18: group = grpJr;
            8'b001??000: group = grpJrCond;
            8'b00??0001: group = grpLdDdNn;
            8'b000?0010: group = grpLdIndBcdeA;
            8'b000?1010: group = grpLdAIndBcde;
            8'h22: group = grpLdIndNnHl;
            8'h2A: group = grpLdHlIndNn;
            8'h32: group = grpLdIndNnA;
            8'h3A: group = grpLdAIndNn;
            8'b00???011: group = grpIncDecDd;
            8'h34, 8'h35: group = grpIncDecIndHl;
            8'b00???10?: group = grpIncDecReg;
            8'h36: group = grpLdIndHlN;
            8'b00???110: group = grpLdRegN;
            8'b000??111: group = grpRrRlca;
            8'h27: group = grpDaa;
            8'h2F: group = grpCpl;
            8'h37: group = grpScf;
            8'h3F: group = grpCcf;
            8'b00??1001: group = grpAddHlDd;
            8'h76: group = grpHalt;
            8'b01110???: group = grpLdIndHlReg;
            // LD r,(HL) has no entry in the table
            8'b01???110: group = grpIllegal;
            8'b01??????: group = grpLdRegReg;
            8'b10???110: group = grpAluAIndHl;
            8'b10??????: group = grpAluAReg;
            8'hC9: group = grpRet;
            8'b11???000: group = grpRetCond;
            8'hC3: group = grpJp;
            8'b11???010: group = grpJpCond;
            8'hE9: group = grpJpIndHl;
            8'hCD: group = grpCall;
            8'b11???100: group = grpCallCond;
            8'b11??0001: group = grpPopQq;
            8'b11??0101: group = grpPushQq;
            8'hE3: group = grpExIndSpHl;
            8'hEB: group = grpExDeHl;
            8'hD9: group = grpExx;
            8'hF9: group = grpLdSpHl;
            8'b11???110: group = grpAluAN;
            8'hF3, 8'hFB: group = grpEiDi;
            // CB lands here too, its group comes from the CB table
            default: group = grpIllegal;
        endcase
    end

    always_comb begin
        case (group)
            grpLdDdNn, grpLdIndNnHl, grpLdHlIndNn, grpLdIndNnA, grpLdAIndNn,
            grpJp, grpJpCond, grpCall, grpCallCond: begin
                length = insnLen_t'(3);
            end
            grpLdRegN, grpLdIndHlN, grpJr, grpJrCond, grpDjnz, grpAluAN: begin
                length = insnLen_t'(2);
            end
            default: begin
                length = (opcode == `Z80_PFX_CB) ? insnLen_t'(2) : insnLen_t'(1);
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/cbOpDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module cbOpDecoder import z80Pkg::*; (
    input  logic [7:0] opcode,
    output insnGroup_e group
);

    logic hlForm;

    // operand field 110 means (HL)
    assign hlForm = (opcode[2:0] == 3'b110);

    always_comb begin
        case (opcode[7:6])
            2'b00: begin
                // 20..3F are the shifts, SLL included
                if (opcode[5]) begin
                    group = hlForm ? grpShiftIndHl : grpShiftReg;
                end else begin
                    group = hlForm ? grpRotIndHl : grpRotReg;
                end
            end
            2'b01: group = hlForm ? grpBitIndHl : grpBitReg;
            2'b10: group = hlForm ? grpResIndHl : grpResReg;
            default: group = hlForm ? grpSetIndHl : grpSetReg;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/instrFramer.sv
`timescale 1ns/1ps
`default_nettype none

`include "z80_config.svh"

module instrFramer import z80Pkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   start,
    input  logic [`Z80_ADDR_W-1:0] startAddr,
    input  logic [7:0]             insnCount,
    output logic                   busy,
    opFetchIf.initiator            fetch,
    output logic [7:0]             baseOpcode,
    input  insnGroup_e             baseGroup,
    input  insnLen_t               baseLength,
    output logic [7:0]             cbOpcode,
    input  insnGroup_e             cbGroup,
    output logic                   insnValid,
    input  logic                   insnReady,
    output logic [`Z80_ADDR_W-1:0] insnAddr,
    output logic [7:0]             insnOpcode,
    output insnGroup_e             insnGroup,
    output insnLen_t               insnLength
);

    framerState_e state;
    logic [`Z80_ADDR_W-1:0] fetchAddr;
    logic [7:0] remaining;
    insnLen_t opLeft;
    logic launch;
    logic accept;

    assign launch = (state == stIdle) && start && (insnCount != 8'd0);
    assign accept = (state == stEmit) && insnReady;

    // request goes out in the start cycle so the bus cycle follows one clock later
    assign fetch.req = launch || (state == stOpcode) || (state == stCbOpcode)
                       || (state == stOperand);
    assign fetch.addr = (state == stIdle) ? startAddr : fetchAddr;

    // both tables look at the byte as it arrives
    assign baseOpcode = fetch.data;
    assign cbOpcode = fetch.data;

    assign busy = (state != stIdle);
    assign insnValid = (state == stEmit);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
            remaining <= 8'd0;
            opLeft <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (launch) begin
                        remaining <= insnCount;
                        state <= stOpcode;
                    end
                end
                stOpcode: begin
                    if (fetch.done) begin
                        if (fetch.data == `Z80_PFX_CB) begin
                            state <= stCbOpcode;
                        end else if (baseLength == insnLen_t'(1)) begin
                            state <= stEmit;
                        end else begin
                            opLeft <= baseLength - insnLen_t'(1);
                            state <= stOperand;
                        end
                    end
                end
                stCbOpcode: begin
                    if (fetch.done) begin
                        state <= stEmit;
                    end
                end
                stOperand: begin
                    if (fetch.done) begin
                        opLeft <= opLeft - insnLen_t'(1);
                        if (opLeft == insnLen_t'(1)) begin
                            state <= stEmit;
                        end
                    end
                end
                stEmit: begin
                    if (insnReady) begin
                        remaining <= remaining - 8'd1;
                        state <= (remaining == 8'd1) ? stIdle : stOpcode;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            fetchAddr <= startAddr;
            insnAddr <= startAddr;
        end else if (fetch.done) begin
            fetchAddr <= fetchAddr + 1'b1;
        end
        if ((state == stOpcode) && fetch.done) begin
            insnOpcode <= fetch.data;
            insnGroup <= baseGroup;
            insnLength <= baseLength;
        end
        if ((state == stCbOpcode) && fetch.done) begin
            insnGroup <= cbGroup;
        end
        // next instruction starts right after the last byte read
        if (accept) begin
            insnAddr <= fetchAddr;
        end
    end

endmodule

`default_nettype wire

//--- hw/z80Predecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "z80_config.svh"

module z80Predecoder import z80Pkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   start,
    input  logic [`Z80_ADDR_W-1:0] startAddr,
    input  logic [7:0]             insnCount,
    output logic                   busy,
    output logic                   wbCyc,
    output logic                   wbStb,
    output logic                   wbWe,
    output logic [`Z80_ADDR_W-1:0] wbAdr,
    input  logic [7:0]             wbDatI,
    input  logic                   wbAck,
    output logic                   insnValid,
    input  logic                   insnReady,
    output logic [`Z80_ADDR_W-1:0] insnAddr,
    output logic [7:0]             insnOpcode,
    output insnGroup_e             insnGroup,
    output insnLen_t               insnLength
);

    logic [7:0] baseOpcode;
    logic [7:0] cbOpcode;
    insnGroup_e baseGroup;
    insnGroup_e cbGroup;
    insnLen_t baseLength;

    opFetchIf fetchBus ();

    wbOpFetch uOpFetch (
        .clk    (clk),
        .arstN  (arstN),
        .fetch  (fetchBus.target),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatI (wbDatI),
        .wbAck  (wbAck)
    );

    instrFramer uFramer (
        .clk        (clk),
        .arstN      (arstN),
        .start      (start),
        .startAddr  (startAddr),
        .insnCount  (insnCount),
        .busy       (busy),
        .fetch      (fetchBus.initiator),
        .baseOpcode (baseOpcode),
        .baseGroup  (baseGroup),
        .baseLength (baseLength),
        .cbOpcode   (cbOpcode),
        .cbGroup    (cbGroup),
        .insnValid  (insnValid),
        .insnReady  (insnReady),
        .insnAddr   (insnAddr),
        .insnOpcode (insnOpcode),
        .insnGroup  (insnGroup),
        .insnLength (insnLength)
    );

    baseOpDecoder uBaseDec (
        .opcode (baseOpcode),
        .group  (baseGroup),
        .length (baseLength)
    );

    cbOpDecoder uCbDec (
        .opcode (cbOpcode),
        .group  (cbGroup)
    );

endmodule

`default_nettype wire

//--- bench/decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// 32-bit LCG with the numerical recipes constants
function automatic logic [31:0] lcgStep(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// unprefixed opcode split into x (7:6), y (5:3) and z (2:0)
function automatic insnGroup_e modelGroup(input logic [7:0] op);
    logic [2:0] y;
    logic [2:0] z;
    insnGroup_e g;
    y = op[5:3];
    z = op[2:0];
    g = grpIllegal;
    case (op[7:6])
        2'd0: begin
            case (z)
                3'd0: g = y[2] ? grpJrCond : (y == 3'd0) ? grpNop
                          : (y == 3'd1) ? grpExAfAf2 : (y == 3'd2) ? grpDjnz : grpJr;
                3'd1: g = y[0] ? grpAddHlDd : grpLdDdNn;
                3'd2: begin
                    if (!y[2]) begin
                        g = y[0] ? grpLdAIndBcde : grpLdIndBcdeA;
                    end else begin
                        g = (y == 3'd4) ? grpLdIndNnHl : (y == 3'd5) ? grpLdHlIndNn
                            : (y == 3'd6) ? grpLdIndNnA : grpLdAIndNn;
                    end
                end
                3'd3: g = grpIncDecDd;
                3'd4, 3'd5: g = (y == 3'd6) ? grpIncDecIndHl : grpIncDecReg;
                3'd6: g = (y == 3'd6) ? grpLdIndHlN : grpLdRegN;
                default: g = !y[2] ? grpRrRlca : (y == 3'd4) ? grpDaa
                             : (y == 3'd5) ? grpCpl : (y == 3'd6) ? grpScf : grpCcf;
            endcase
        end
        2'd1: begin
            // (HL) as destination is listed, (HL) as source is not
            if (op == 8'h76) g = grpHalt;
            else if (y == 3'd6) g = grpLdIndHlReg;
            else if (z == 3'd6) g = grpIllegal;
            else g = grpLdRegReg;
        end
        2'd2: g = (z == 3'd6) ? grpAluAIndHl : grpAluAReg;
        default: begin
            case (z)
                3'd0: g = grpRetCond;
                3'd1: g = !y[0] ? grpPopQq : (y == 3'd1) ? grpRet : (y == 3'd3) ? grpExx
                          : (y == 3'd5) ? grpJpIndHl : grpLdSpHl;
                3'd2: g = grpJpCond;
                3'd3: g = (y == 3'd0) ? grpJp : (y == 3'd4) ? grpExIndSpHl
                          : (y == 3'd5) ? grpExDeHl : y[2] ? grpEiDi : grpIllegal;
                3'd4: g = grpCallCond;
                // DD, ED and FD share z=5 with odd y
                3'd5: g = !y[0] ? grpPushQq : (y == 3'd1) ? grpCall : grpUnsupportedPrefix;
                3'd6: g = grpAluAN;
                default: g = grpIllegal;
            endcase
        end
    endcase
    return g;
endfunction

// CB second byte sorted by value range
function automatic insnGroup_e modelCbGroup(input logic [7:0] op);
    logic hl;
    hl = (op[2:0] == 3'd6);
    if (op < 8'h20) return hl ? grpRotIndHl : grpRotReg;
    if (op < 8'h40) return hl ? grpShiftIndHl : grpShiftReg;
    if (op < 8'h80) return hl ? grpBitIndHl : grpBitReg;
    if (op < 8'hC0) return hl ? grpResIndHl : grpResReg;
    return hl ? grpSetIndHl : grpSetReg;
endfunction

// length from the opcode fields with the immediate bytes included
function automatic insnLen_t modelLength(input logic [7:0] op);
    logic [2:0] y;
    logic [2:0] z;
    y = op[5:3];
    z = op[2:0];
    if (op[7:6] == 2'd0) begin
        // DJNZ, JR and JR cc carry a displacement
        if (z == 3'd0) return (y >= 3'd2) ? 2'd2 : 2'd1;
        if (z == 3'd1) return y[0] ? 2'd1 : 2'd3;
        if (z == 3'd2) return y[2] ? 2'd3 : 2'd1;
        if (z == 3'd6) return 2'd2;
    end else if (op[7:6] == 2'd3) begin
        if (z == 3'd2 || z == 3'd4) return 2'd3;
        // y=1 here is the CB prefix
        if (z == 3'd3) return (y == 3'd0) ? 2'd3 : (y == 3'd1) ? 2'd2 : 2'd1;
        if (z == 3'd5) return (y == 3'd1) ? 2'd3 : 2'd1;
        if (z == 3'd6) return 2'd2;
    end
    return 2'd1;
endfunction

`endif

//--- bench/tbZ80Predecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "z80_config.svh"

module tbZ80Predecoder import z80Pkg::*; ();

    `include "decodeModel.svh"

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  op;
        insnGroup_e  grp;
        insnLen_t    len;
    } record_t;

    localparam int randRuns = 4;
    localparam int randInsns = 200;
    localparam int oddCount = 20;
    localparam int totalInsns = randRuns * randInsns + 256 + oddCount;
    // 3 bytes of up to 6 cycles each per instruction
    localparam int watchdogNs = totalInsns * 3 * 6 * 20 + 100000;

    // prefixes first and then opcodes missing from the table
    localparam logic [7:0] oddOps [0:oddCount-1] = '{
        8'hED, 8'hDD, 8'hFD, 8'hD3, 8'hDB, 8'hC7, 8'hCF, 8'hD7, 8'hDF, 8'hE7,
        8'hEF, 8'hF7, 8'hFF, 8'h46, 8'h4E, 8'h56, 8'h5E, 8'h66, 8'h6E, 8'h7E
    };

    logic clk;
    logic arstN;
    logic start;
    logic [15:0] startAddr;
    logic [7:0] insnCount;
    logic busy;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [15:0] wbAdr;
    logic [7:0] wbDatI;
    logic wbAck;
    logic insnValid;
    logic insnReady;
    logic [15:0] insnAddr;
    logic [7:0] insnOpcode;
    insnGroup_e insnGroup;
    insnLen_t insnLength;

    logic [7:0] mem [0:65535];
    record_t expQ [$];
    record_t heldRec;
    logic holding;
    logic inCycle;
    logic [15:0] cycAddr;
    logic [15:0] busAddr;
    logic [31:0] busRand;
    int waitLeft;
    int accepted;
    int recordsSeen;
    int errors;

    z80Predecoder u_dut (
        .clk        (clk),
        .arstN      (arstN),
        .start      (start),
        .startAddr  (startAddr),
        .insnCount  (insnCount),
        .busy       (busy),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbWe       (wbWe),
        .wbAdr      (wbAdr),
        .wbDatI     (wbDatI),
        .wbAck      (wbAck),
        .insnValid  (insnValid),
        .insnReady  (insnReady),
        .insnAddr   (insnAddr),
        .insnOpcode (insnOpcode),
        .insnGroup  (insnGroup),
        .insnLength (insnLength)
    );

    always #10 clk = ~clk;

    task automatic reportFail(input string msg);
        $display("FAIL @%0t: %s", $time, msg);
        errors++;
    endtask

    // walk memory from an address and queue the records it should give
    task automatic predictRecords(input logic [15:0] from, input int count);
        logic [15:0] a;
        record_t rec;
        a = from;
        for (int i = 0; i < count; i++) begin
            rec.addr = a;
            rec.op = mem[a];
            rec.len = modelLength(rec.op);
            if (rec.op == `Z80_PFX_CB) begin
                rec.grp = modelCbGroup(mem[a + 16'd1]);
            end else begin
                rec.grp = modelGroup(rec.op);
            end
            expQ.push_back(rec);
            a = a + {14'd0, rec.len};
        end
    endtask

    task automatic launchRun(input logic [15:0] from, input int count);
        accepted = 0;
        busAddr = from;
        @(negedge clk);
        start = 1'b1;
        startAddr = from;
        insnCount = 8'(count);
        @(negedge clk);
        start = 1'b0;
        if (!wbCyc) reportFail("wbCyc did not rise one cycle after start");
        wait (accepted == count);
        @(negedge clk);
        if (busy) reportFail("busy still high the cycle after the last record");
        repeat (3) begin
            @(negedge clk);
            if (insnValid || busy) reportFail("activity after the last record");
        end
        if (expQ.size() != 0) reportFail($sformatf("%0d records missing", expQ.size()));
    endtask

    // memory slave and record sink on the falling edge
    always @(negedge clk) begin
        record_t want;
        if (arstN) begin
            if (wbWe !== 1'b0 || wbStb !== wbCyc) begin
                reportFail("wbWe high or wbStb not matching wbCyc");
            end
            if (wbAck) begin
                wbAck = 1'b0;
                if (wbCyc) reportFail("wbCyc still high in the cycle after wbAck");
            end else if (wbCyc) begin
                if (!inCycle) begin
                    inCycle = 1'b1;
                    cycAddr = wbAdr;
                    // bytes are read one after another from the start address
                    if (wbAdr !== busAddr) begin
                        reportFail($sformatf("read from %h, expected %h", wbAdr, busAddr));
                    end
                    busAddr = busAddr + 16'd1;
                    busRand = lcgStep(busRand);
                    waitLeft = int'(busRand[17:16]);
                end else if (wbAdr !== cycAddr) begin
                    reportFail($sformatf("wbAdr moved from %h to %h", cycAddr, wbAdr));
                end
                if (waitLeft == 0) begin
                    wbAck = 1'b1;
                    wbDatI = mem[wbAdr];
                    inCycle = 1'b0;
                end else begin
                    waitLeft--;
                end
            end

            if (insnValid) begin
                if (wbCyc) reportFail("bus cycle open while a record is pending");
                if (holding && {insnAddr, insnOpcode, insnGroup, insnLength} !== heldRec) begin
                    reportFail("record changed while insnReady was low");
                end
                if (!holding) begin
                    recordsSeen++;
                    heldRec = {insnAddr, insnOpcode, insnGroup, insnLength};
                    holding = 1'b1;
                    if (expQ.size() == 0) begin
                        reportFail("record beyond insnCount");
                    end else begin
                        want = expQ.pop_front();
                        if (heldRec !== want) begin
                            reportFail($sformatf(
                                "record %h/%h/%0d/%0d, expected %h/%h/%0d/%0d",
                                insnAddr, insnOpcode, insnGroup, insnLength,
                                want.addr, want.op, want.grp, want.len));
                        end
                    end
                end
                busRand = lcgStep(busRand);
                insnReady = (busRand[19:18] != 2'd0);
                if (insnReady) begin
                    holding = 1'b0;
                    accepted++;
                end
            end else begin
                insnReady = 1'b0;
            end
        end
    end

    initial begin
        logic [31:0] r;
        record_t rec;
        clk = 1'b0;
        arstN = 1'b0;
        start = 1'b0;
        startAddr = 16'd0;
        insnCount = 8'd0;
        insnReady = 1'b0;
        wbDatI = 8'd0;
        wbAck = 1'b0;
        holding = 1'b0;
        inCycle = 1'b0;
        busAddr = 16'd0;
        waitLeft = 0;
        errors = 0;
        recordsSeen = 0;
        accepted = 0;

        r = 32'h6813;
        for (int a = 0; a < 65536; a++) begin
            r = lcgStep(r);
            mem[a] = r[23:16];
        end
        busRand = lcgStep(r);

        @(negedge clk);
        if (wbCyc || wbStb || insnValid || busy) reportFail("outputs not low during reset");
        @(negedge clk);
        arstN = 1'b1;

        for (int i = 0; i < randRuns; i++) begin
            r = lcgStep(r);
            predictRecords(r[31:16], randInsns);
            launchRun(r[31:16], randInsns);
        end

        // every CB second byte once
        for (int i = 0; i < 256; i++) begin
            mem[16'h8000 + 2 * i] = `Z80_PFX_CB;
            mem[16'h8000 + 2 * i + 1] = 8'(i);
        end
        predictRecords(16'h8000, 128);
        launchRun(16'h8000, 128);
        predictRecords(16'h8100, 128);
        launchRun(16'h8100, 128);

        for (int i = 0; i < oddCount; i++) begin
            mem[16'h9000 + i] = oddOps[i];
            rec.addr = 16'h9000 + 16'(i);
            rec.op = oddOps[i];
            rec.grp = (i < 3) ? grpUnsupportedPrefix : grpIllegal;
            rec.len = 2'd1;
            expQ.push_back(rec);
        end
        launchRun(16'h9000, oddCount);

        $display("checked %0d records, %0d errors", recordsSeen, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("watchdog expired with %0d records still expected", expQ.size());
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
+incdir+bench
hw/z80Pkg.sv
hw/opFetchIf.sv
hw/wbOpFetch.sv
hw/baseOpDecoder.sv
hw/cbOpDecoder.sv
hw/instrFramer.sv
hw/z80Predecoder.sv
bench/tbZ80Predecoder.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f \
    --top-module tbZ80Predecoder -o simZ80Predecoder

./obj_dir/simZ80Predecoder | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "run.sh: pass"
else
    echo "run.sh: fail"
    exit 1
fi
